/* waveGenPkg.sv */
package waveGenPkg;

    // Timebase and SPI framing, all in clk cycles
    localparam int SampleDiv = 2000;            // Clocks per sample strobe
    localparam int SpiDiv    = 8;               // Clocks per SPI bit
    localparam int CsGap     = 8;               // csN high between words
    localparam int LdacLen   = 8;               // ldacN low pulse
    localparam int DacBits   = 12;
    localparam int PhaseBits = 32;

    // Sample ticker counter
    localparam int SampleCntBits = $clog2(SampleDiv);
    typedef logic [SampleCntBits-1:0] sampleCnt_t;
    localparam sampleCnt_t SampleLast = sampleCnt_t'(SampleDiv - 1);

    // Serializer phase counter, sized for the longest of the three phases
    typedef logic [3:0] serCnt_t;
    localparam serCnt_t SpiHalf   = serCnt_t'(SpiDiv / 2 - 1);   // sclk rises here
    localparam serCnt_t SpiLast   = serCnt_t'(SpiDiv - 1);       // End of bit
    localparam serCnt_t CsGapLast = serCnt_t'(CsGap - 1);
    localparam serCnt_t LdacLast  = serCnt_t'(LdacLen - 1);

    typedef logic [DacBits-1:0] sample_t;       // Unsigned DAC code

    typedef enum logic [1:0]
    {
        ModeDc,
        ModeSaw,
        ModeTri,
        ModeSquare
    } waveMode_e;

    // 58 bits per channel
    typedef struct packed
    {
        waveMode_e              mode;
        logic [DacBits-1:0]     amplitude;      // 4095 is nearly full scale
        sample_t                offset;
        logic [PhaseBits-1:0]   phaseStep;
    } chanCfg_t;

    typedef struct packed
    {
        sample_t a;
        sample_t b;
    } samplePair_t;

    // DAC command word, MSB first on the wire
    typedef struct packed
    {
        logic    chanB;                         // 0 selects DAC A
        logic    bufRef;                        // Unbuffered reference
        logic    gainN;                         // 1 for gain of one
        logic    shdnN;                         // 1 keeps output active
        sample_t data;
    } dacCmd_t;

    // Built as fields, shifted as bits
    typedef union packed
    {
        dacCmd_t     cmd;
        logic [15:0] raw;
    } dacWord_u;

endpackage

/* sampleTicker.sv */
module sampleTicker
(
    input  logic clk,
    input  logic rstN,
    output logic tick
);

    waveGenPkg::sampleCnt_t cnt;

    // Free running divider, one tick per wrap
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            tick <= (cnt == waveGenPkg::SampleLast);    // First tick SampleDiv clocks in
            if (cnt == waveGenPkg::SampleLast)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
        end
    end

endmodule

/* waveChannel.sv */
module waveChannel
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   tick,
    input  waveGenPkg::chanCfg_t   cfg,
    output waveGenPkg::sample_t    sample,
    output logic                   sampleValid
);

    waveGenPkg::chanCfg_t             cfgQ;         // Config seen at the last tick
    logic [waveGenPkg::PhaseBits-1:0] phase;        // Accumulator
    logic [waveGenPkg::PhaseBits-1:0] shapePhase;   // Phase this sample is built from
    waveGenPkg::sample_t              shape;
    logic [2*waveGenPkg::DacBits-1:0] prod;
    logic [waveGenPkg::DacBits:0]     sum;          // One carry bit for saturation

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            phase       <= '0;
            sampleValid <= 1'b0;
        end
        else
        begin
            sampleValid <= tick;
            if (tick)
                phase <= phase + cfg.phaseStep;     // Step taken after sampling
        end
    end

    // Snapshot for the shaping logic below
    always_ff @(posedge clk)
    begin
        if (tick)
        begin
            cfgQ       <= cfg;
            shapePhase <= phase;
        end
    end

    // Shape from the top of the phase
    always_comb
    begin
        case (cfgQ.mode)
            waveGenPkg::ModeSaw:
                shape = shapePhase[31:20];
            waveGenPkg::ModeTri:
            begin
                // Rising half then falling half
                if (shapePhase[31])
                    shape = ~shapePhase[30:19];
                else
                    shape = shapePhase[30:19];
            end
            waveGenPkg::ModeSquare:
                shape = shapePhase[31] ? '0 : '1;   // Fixed half duty
            default:
                shape = '0;                         // DC is offset only
        endcase
    end

    // Scale by amplitude/4096, truncating
    assign prod = shape * cfgQ.amplitude;
    assign sum  = {1'b0, cfgQ.offset} + {1'b0, prod[23:12]};

    // Clamp at full scale
    assign sample = sum[waveGenPkg::DacBits] ? '1 : sum[waveGenPkg::DacBits-1:0];

endmodule

/* dacFrameBuffer.sv */
module dacFrameBuffer
(
    input  logic                     clk,
    input  logic                     rstN,
    input  waveGenPkg::samplePair_t  pair,
    input  logic                     pairValid,
    input  logic                     busy,
    output logic                     frameStart,
    output waveGenPkg::dacWord_u     wordA,
    output waveGenPkg::dacWord_u     wordB
);

    waveGenPkg::samplePair_t pairQ;     // Newest pair
    logic                    pending;
    logic                    issue;

    // Serializer raises busy one clock after frameStart
    assign issue = pending && !busy && !frameStart;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pending    <= 1'b0;
            frameStart <= 1'b0;
        end
        else
        begin
            frameStart <= issue;
            if (pairValid)
                pending <= 1'b1;            // Newer pair keeps its own frame
            else if (issue)
                pending <= 1'b0;
        end
    end

    // Pair store, overwritten by newer data
    always_ff @(posedge clk)
    begin
        if (pairValid)
            pairQ <= pair;
    end

    // Words frozen at frame issue
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            wordA.cmd.chanB  <= 1'b0;
            wordA.cmd.bufRef <= 1'b0;
            wordA.cmd.gainN  <= 1'b1;
            wordA.cmd.shdnN  <= 1'b1;
            wordA.cmd.data   <= pairQ.a;
            wordB.cmd.chanB  <= 1'b1;
            wordB.cmd.bufRef <= 1'b0;
            wordB.cmd.gainN  <= 1'b1;
            wordB.cmd.shdnN  <= 1'b1;
            wordB.cmd.data   <= pairQ.b;
        end
    end

endmodule

/* dacSpiSerializer.sv */
module dacSpiSerializer
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  frameStart,
    input  waveGenPkg::dacWord_u  wordA,
    input  waveGenPkg::dacWord_u  wordB,
    output logic                  busy,
    output logic                  csN,
    output logic                  sclk,
    output logic                  sdi,
    output logic                  ldacN
);

    typedef enum logic [2:0]
    {
        StIdle,
        StWordA,
        StGap,
        StWordB,
        StLoad
    } serState_e;

    serState_e           state;
    waveGenPkg::serCnt_t cnt;           // Clocks within a bit, gap or load pulse
    logic [3:0]          bitCnt;        // Bits sent of the current word
    logic [15:0]         shReg;         // MSB drives sdi
    logic [15:0]         wordBQ;        // Second word waits here

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state  <= StIdle;
            cnt    <= '0;
            bitCnt <= '0;
            busy   <= 1'b0;
            csN    <= 1'b1;
            sclk   <= 1'b0;
            sdi    <= 1'b0;
            ldacN  <= 1'b1;
        end
        else
        begin
            case (state)
                StIdle:
                begin
                    if (frameStart)
                    begin
                        busy   <= 1'b1;
                        csN    <= 1'b0;
                        sdi    <= wordA.raw[15];    // First bit set up with sclk low
                        cnt    <= '0;
                        bitCnt <= '0;
                        state  <= StWordA;
                    end
                end
                StWordA, StWordB:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == waveGenPkg::SpiHalf)
                        sclk <= 1'b1;               // DAC samples here
                    if (cnt == waveGenPkg::SpiLast)
                    begin
                        sclk <= 1'b0;
                        cnt  <= '0;
                        if (bitCnt == 4'hF)
                        begin
                            csN <= 1'b1;
                            sdi <= 1'b0;
                            if (state == StWordA)
                                state <= StGap;
                            else
                            begin
                                ldacN <= 1'b0;      // Both words in, update outputs
                                state <= StLoad;
                            end
                        end
                        else
                        begin
                            bitCnt <= bitCnt + 1'b1;
                            sdi    <= shReg[14];
                        end
                    end
                end
                StGap:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == waveGenPkg::CsGapLast)
                    begin
                        csN    <= 1'b0;
                        sdi    <= wordBQ[15];
                        cnt    <= '0;
                        bitCnt <= '0;
                        state  <= StWordB;
                    end
                end
                StLoad:
                begin
                    cnt <= cnt + 1'b1;
                    if (cnt == waveGenPkg::LdacLast)
                    begin
                        ldacN <= 1'b1;
                        busy  <= 1'b0;
                        cnt   <= '0;
                        state <= StIdle;
                    end
                end
                default:
                    state <= StIdle;
            endcase
        end
    end

    // Shift path, loaded per word and stepped at each bit end
    always_ff @(posedge clk)
    begin
        if (state == StIdle && frameStart)
        begin
            shReg  <= wordA.raw;
            wordBQ <= wordB.raw;
        end
        else if (state == StGap && cnt == waveGenPkg::CsGapLast)
            shReg <= wordBQ;
        else if ((state == StWordA || state == StWordB) && cnt == waveGenPkg::SpiLast)
            shReg <= {shReg[14:0], 1'b0};
    end

endmodule

/* waveGenTop.sv */
module waveGenTop
(
    input  logic                  clk,
    input  logic                  rstN,
    input  waveGenPkg::chanCfg_t  cfgA,
    input  waveGenPkg::chanCfg_t  cfgB,
    output logic                  csN,
    output logic                  sclk,
    output logic                  sdi,
    output logic                  ldacN
);

    logic                    tick;
    waveGenPkg::sample_t     sampleA;
    waveGenPkg::sample_t     sampleB;
    logic                    pairValid;     // Both channels valid together
    waveGenPkg::samplePair_t pair;
    logic                    frameStart;
    logic                    busy;
    waveGenPkg::dacWord_u    wordA;
    waveGenPkg::dacWord_u    wordB;

    assign pair.a = sampleA;
    assign pair.b = sampleB;

    sampleTicker u_ticker
    (
        .clk  (clk),
        .rstN (rstN),
        .tick (tick)
    );

    waveChannel chanA
    (
        .clk         (clk),
        .rstN        (rstN),
        .tick        (tick),
        .cfg         (cfgA),
        .sample      (sampleA),
        .sampleValid (pairValid)
    );

    // Same tick, so A's valid covers B
    waveChannel chanB
    (
        .clk         (clk),
        .rstN        (rstN),
        .tick        (tick),
        .cfg         (cfgB),
        .sample      (sampleB),
        .sampleValid ()
    );

    dacFrameBuffer u_buffer
    (
        .clk        (clk),
        .rstN       (rstN),
        .pair       (pair),
        .pairValid  (pairValid),
        .busy       (busy),
        .frameStart (frameStart),
        .wordA      (wordA),
        .wordB      (wordB)
    );

    dacSpiSerializer u_serializer
    (
        .clk        (clk),
        .rstN       (rstN),
        .frameStart (frameStart),
        .wordA      (wordA),
        .wordB      (wordB),
        .busy       (busy),
        .csN        (csN),
        .sclk       (sclk),
        .sdi        (sdi),
        .ldacN      (ldacN)
    );

endmodule

/* tbClockGen.sv */
module tbClockGen
(
    input  logic resetReq,          // Restarts the reset pulse
    output logic clk,
    output logic rstN
);

    int cnt;                        // Reset edges counted so far

    initial
    begin
        clk  = 1'b0;
        rstN = 1'b0;
        cnt  = 0;
    end

    always #20 clk = ~clk;          // Period 40

    // rstN low for 5 rising edges, at start and on each request
    always @(posedge clk)
    begin
        if (resetReq)
        begin
            cnt  <= 0;
            rstN <= 1'b0;
        end
        else if (cnt < 5)
        begin
            cnt  <= cnt + 1;
            rstN <= (cnt == 4);
        end
    end

endmodule

/* waveGenTb.sv */
module waveGenTb;

    logic                 clk;
    logic                 rstN;
    logic                 resetReq;
    waveGenPkg::chanCfg_t cfgA;
    waveGenPkg::chanCfg_t cfgB;
    logic                 csN;
    logic                 sclk;
    logic                 sdi;
    logic                 ldacN;
    logic [31:0]          lfsr;                 // Random source state

    tbClockGen u_clkGen
    (
        .resetReq (resetReq),
        .clk      (clk),
        .rstN     (rstN)
    );

    waveGenTop u_dut
    (
        .clk   (clk),
        .rstN  (rstN),
        .cfgA  (cfgA),
        .cfgB  (cfgB),
        .csN   (csN),
        .sclk  (sclk),
        .sdi   (sdi),
        .ldacN (ldacN)
    );

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic checkWord(input string name, input waveGenPkg::dacWord_u got,
                             input waveGenPkg::dacWord_u exp);
        if (got !== exp)
            failNow($sformatf("MISMATCH %s got %h expected %h", name, got.raw, exp.raw));
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp)
            failNow($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
    endtask

    // Galois form with taps 32 30 26 25
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsrNext(lfsr);              // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // Reference sample n of a channel from phase 0
    function automatic waveGenPkg::sample_t modelSample(input waveGenPkg::chanCfg_t cfg,
                                                        input int n);
        logic [31:0] ph;
        logic [11:0] shape;
        int          total;
        ph = cfg.phaseStep * 32'(n);            // Wraps mod 2^32
        case (cfg.mode)
            waveGenPkg::ModeSaw:    shape = ph[31:20];
            waveGenPkg::ModeTri:    shape = ph[31] ? ~ph[30:19] : ph[30:19];
            waveGenPkg::ModeSquare: shape = ph[31] ? 12'h000 : 12'hFFF;
            default:                shape = 12'h000;
        endcase
        total = int'(cfg.offset) + (int'(shape) * int'(cfg.amplitude)) / 4096;
        if (total > 4095)
            total = 4095;                       // Clamp at full scale
        return waveGenPkg::sample_t'(total);
    endfunction

    function automatic waveGenPkg::dacWord_u expectWord(input logic chanB,
                                                        input waveGenPkg::sample_t data);
        waveGenPkg::dacWord_u w;
        w.cmd.chanB  = chanB;
        w.cmd.bufRef = 1'b0;
        w.cmd.gainN  = 1'b1;
        w.cmd.shdnN  = 1'b1;
        w.cmd.data   = data;
        return w;
    endfunction

    function automatic waveGenPkg::chanCfg_t makeCfg(input waveGenPkg::waveMode_e mode,
                                                     input logic [11:0] amp,
                                                     input waveGenPkg::sample_t off,
                                                     input logic [31:0] step);
        waveGenPkg::chanCfg_t c;
        c.mode      = mode;
        c.amplitude = amp;
        c.offset    = off;
        c.phaseStep = step;
        return c;
    endfunction

    // Config set under reset so both phases restart at 0
    task automatic startTest(input waveGenPkg::chanCfg_t a, input waveGenPkg::chanCfg_t b);
        int waited;
        @(posedge clk);
        resetReq <= 1'b1;
        @(posedge clk);
        resetReq <= 1'b0;
        cfgA     <= a;                          // rstN falls on this edge
        cfgB     <= b;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
            if (waited > 20)
                failNow("reset was never released");
        end
        while (!rstN);
        repeat (16)                             // Idle bus before the first tick
        begin
            @(posedge clk);
            checkLevel("csN", csN, 1'b1);
            checkLevel("ldacN", ldacN, 1'b1);
            checkLevel("sclk", sclk, 1'b0);
        end
    endtask

    task automatic waitCsLow(input string what, input int limit);
        int waited;
        waited = 0;
        do
        begin
            @(posedge clk);
            checkLevel("ldacN", ldacN, 1'b1);   // No load before a word
            waited++;
            if (waited > limit)
                failNow($sformatf("timeout waiting for csN to fall before %s", what));
        end
        while (csN);
    endtask

    // sdi taken where the sampled sclk goes from low to high
    task automatic shiftInWord(input string what, output logic [15:0] bits);
        int   count;
        int   waited;
        logic prevSclk;
        bits     = '0;
        count    = 0;
        waited   = 0;
        prevSclk = 1'b0;
        do
        begin
            @(posedge clk);
            if (!csN)
                checkLevel("ldacN", ldacN, 1'b1);   // No load while a word shifts
            if (!csN && sclk && !prevSclk)
            begin
                bits = {bits[14:0], sdi};
                count++;
            end
            prevSclk = sclk;
            waited++;
            if (waited > 20 * waveGenPkg::SpiDiv)
                failNow($sformatf("timeout waiting for csN to rise after %s", what));
        end
        while (!csN);
        if (count != 16)
            failNow($sformatf("%s carried %0d SPI clocks instead of 16", what, count));
    endtask

    task automatic captureFrame(output waveGenPkg::dacWord_u wa,
                                output waveGenPkg::dacWord_u wb);
        logic [15:0] bits;
        int          waited;
        logic        seenLow;
        waitCsLow("word A", 3 * waveGenPkg::SampleDiv);
        shiftInWord("word A", bits);
        wa.raw = bits;
        waitCsLow("word B", 2 * waveGenPkg::CsGap);     // Gap has csN high
        shiftInWord("word B", bits);
        wb.raw = bits;
        seenLow = !ldacN;
        waited  = 0;
        while (!(seenLow && ldacN))             // One load pulse with csN held high
        begin
            @(posedge clk);
            checkLevel("csN", csN, 1'b1);
            seenLow = seenLow || !ldacN;
            waited++;
            if (waited > 4 * waveGenPkg::LdacLen)
                failNow("ldacN pulse missing or too long after word B");
        end
    endtask

    task automatic runFrames(input int frames);
        waveGenPkg::dacWord_u wa;
        waveGenPkg::dacWord_u wb;
        for (int n = 0; n < frames; n++)
        begin
            captureFrame(wa, wb);
            checkWord($sformatf("frame %0d word A", n), wa,
                      expectWord(1'b0, modelSample(cfgA, n)));
            checkWord($sformatf("frame %0d word B", n), wb,
                      expectWord(1'b1, modelSample(cfgB, n)));
        end
    endtask

    task automatic dcLevels();
        startTest(makeCfg(waveGenPkg::ModeDc, 12'hFFF, 12'h123, 32'h0100_0000),
                  makeCfg(waveGenPkg::ModeDc, 12'h800, 12'hABC, 32'h0000_0000));
        runFrames(3);
    endtask

    // Ramp wraps after about five samples
    task automatic sawWrap();
        startTest(makeCfg(waveGenPkg::ModeSaw, 12'hFFF, 12'h000, 32'h3000_0000),
                  makeCfg(waveGenPkg::ModeDc, 12'h000, 12'h400, 32'h0000_0000));
        runFrames(8);
    endtask

    task automatic triSaturate();
        startTest(makeCfg(waveGenPkg::ModeTri, 12'hFFF, 12'h900, 32'h1800_0000),
                  makeCfg(waveGenPkg::ModeTri, 12'h800, 12'h100, 32'h2800_0000));
        runFrames(12);                          // Over one full period of A
    endtask

    task automatic squareWithSaw();
        logic [31:0] stepA;
        logic [31:0] stepB;
        logic [31:0] ampA;
        logic [31:0] ampB;
        logic [31:0] offA;
        stepA = randBits(32);
        stepB = 32'h2000_0000 | randBits(29);   // Both halves seen in six samples
        ampA  = randBits(12);
        ampB  = randBits(12);
        offA  = randBits(8);
        startTest(makeCfg(waveGenPkg::ModeSaw, ampA[11:0], offA[11:0], stepA),
                  makeCfg(waveGenPkg::ModeSquare, ampB[11:0], 12'h000, stepB));
        runFrames(6);
    endtask

    initial
    begin
        lfsr     = 32'h4320_d7ba;
        resetReq = 1'b0;
        cfgA     = '0;
        cfgB     = '0;
        dcLevels();
        sawWrap();
        triSaturate();
        squareWithSaw();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* files.f */
waveGenPkg.sv
sampleTicker.sv
waveChannel.sv
dacFrameBuffer.sv
dacSpiSerializer.sv
waveGenTop.sv
tbClockGen.sv
waveGenTb.sv

/* Makefile */
SRCS := $(shell cat files.f)
BIN  := obj_dir/VwaveGenTb

.PHONY: run clean

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "TESTS PASSED"

$(BIN): files.f $(SRCS)
	verilator --binary --timing -j 0 --top-module waveGenTb -f files.f

clean:
	rm -rf obj_dir
